/* verilog/btac_pkg.sv */
package btac_pkg;

  localparam int pc_w = 32;
  localparam int sat_w = 2;

  localparam int btb_entries = 64;
  localparam int btb_index_w = 6;

  // The index skips bit 0 of the PC.
  localparam int btb_index_lsb = 1;
  localparam int btb_tag_lsb = btb_index_lsb + btb_index_w;
  localparam int btb_tag_w = pc_w - btb_tag_lsb;

  // Stored word is {tag, target, counter}.
  localparam int entry_sat_lsb = 0;
  localparam int entry_target_lsb = entry_sat_lsb + sat_w;
  localparam int entry_tag_lsb = entry_target_lsb + pc_w;
  localparam int btb_entry_w = entry_tag_lsb + btb_tag_w;

  localparam int sat_taken_bit = 1; // Counter MSB predicts taken.

  typedef logic [pc_w-1:0] pc_t;
  typedef logic [btb_index_w-1:0] btb_index_t;
  typedef logic [btb_tag_w-1:0] btb_tag_t;
  typedef logic [sat_w-1:0] sat_t;
  typedef logic [btb_entry_w-1:0] btb_entry_t;

  function automatic btb_index_t pc_index(input pc_t pc);
    return pc[btb_index_lsb +: btb_index_w];
  endfunction

  function automatic btb_tag_t pc_tag(input pc_t pc);
    return pc[btb_tag_lsb +: btb_tag_w];
  endfunction

  function automatic btb_tag_t entry_tag(input btb_entry_t entry);
    return entry[entry_tag_lsb +: btb_tag_w];
  endfunction

  function automatic pc_t entry_target(input btb_entry_t entry);
    return entry[entry_target_lsb +: pc_w];
  endfunction

  function automatic sat_t entry_sat(input btb_entry_t entry);
    return entry[entry_sat_lsb +: sat_w];
  endfunction

  function automatic btb_entry_t make_entry(input btb_tag_t tag, input pc_t target,
                                            input sat_t sat);
    return {tag, target, sat};
  endfunction

endpackage

/* verilog/btb_if.sv */
`timescale 1ns/1ps

interface btb_if import btac_pkg::*; ();

  logic wen;
  btb_index_t waddr;
  btb_entry_t wdata;

  btb_index_t raddr0;
  btb_index_t raddr1;
  btb_entry_t rdata0;
  btb_entry_t rdata1;

  // Training side.
  modport write (
    output wen, waddr, wdata
  );

  // Lookup side.
  modport read (
    output raddr0, raddr1,
    input rdata0, rdata1
  );

  modport mem (
    input wen, waddr, wdata, raddr0, raddr1,
    output rdata0, rdata1
  );

endinterface

/* verilog/btb_mem.sv */
`timescale 1ns/1ps

module btb_mem import btac_pkg::*; (
  input logic clock,
  btb_if.mem btb
);

  // Zero counters never predict taken.
  btb_entry_t array_q [btb_entries] = '{default: '0};

  btb_index_t raddr0_q = '0;
  btb_index_t raddr1_q = '0;

  always_ff @(posedge clock) begin
    raddr0_q <= btb.raddr0;
    raddr1_q <= btb.raddr1;
    if (btb.wen) begin
      array_q[btb.waddr] <= btb.wdata;
    end
  end

  // Async read from the registered addresses.
  assign btb.rdata0 = array_q[raddr0_q];
  assign btb.rdata1 = array_q[raddr1_q];

endmodule

/* verilog/btac_lookup.sv */
`timescale 1ns/1ps

module btac_lookup import btac_pkg::*; (
  input logic clock,
  input logic reset,
  input pc_t get_pc0_i,
  input pc_t get_pc1_i,
  input logic stall_i,
  input logic clear_i,
  btb_if.read btb,
  output logic pred_taken0_o,
  output logic pred_taken1_o,
  output pc_t pred_taddr0_o,
  output pc_t pred_taddr1_o,
  output sat_t pred_tsat0_o,
  output sat_t pred_tsat1_o
);

  pc_t pc0_q;
  pc_t pc1_q;
  btb_index_t idx0_q;
  btb_index_t idx1_q;

  sat_t sat0;
  sat_t sat1;
  logic hit0;
  logic hit1;
  logic gate;

  // Stall does not hold the PCs, only clear does.
  always_ff @(posedge clock) begin
    if (!reset) begin
      pc0_q <= '0;
      pc1_q <= '0;
      idx0_q <= '0;
      idx1_q <= '0;
    end else if (!clear_i) begin
      pc0_q <= get_pc0_i;
      pc1_q <= get_pc1_i;
      idx0_q <= pc_index(get_pc0_i);
      idx1_q <= pc_index(get_pc1_i);
    end
  end

  // Held index is replayed during clear.
  assign btb.raddr0 = clear_i ? idx0_q : pc_index(get_pc0_i);
  assign btb.raddr1 = clear_i ? idx1_q : pc_index(get_pc1_i);

  assign sat0 = entry_sat(btb.rdata0);
  assign sat1 = entry_sat(btb.rdata1);

  assign hit0 = (entry_tag(btb.rdata0) == pc_tag(pc0_q)) && sat0[sat_taken_bit];
  assign hit1 = (entry_tag(btb.rdata1) == pc_tag(pc1_q)) && sat1[sat_taken_bit];

  assign gate = stall_i | clear_i;

  assign pred_taken0_o = hit0 & ~gate;
  assign pred_taken1_o = hit1 & ~gate;
  assign pred_taddr0_o = gate ? '0 : entry_target(btb.rdata0);
  assign pred_taddr1_o = gate ? '0 : entry_target(btb.rdata1);
  assign pred_tsat0_o = gate ? '0 : sat0; // Raw counter, tag not checked.
  assign pred_tsat1_o = gate ? '0 : sat1;

endmodule

/* verilog/btac_update.sv */
`timescale 1ns/1ps

module btac_update import btac_pkg::*; (
  input logic clock,
  input logic reset,
  input logic clear_i,
  input pc_t upd_pc0_i,
  input pc_t upd_npc0_i,
  input pc_t upd_addr0_i,
  input logic upd_branch0_i,
  input logic upd_jal0_i,
  input logic upd_jump0_i,
  input logic upd_taken0_i,
  input pc_t upd_taddr0_i,
  input sat_t upd_tsat0_i,
  input pc_t upd_pc1_i,
  input pc_t upd_npc1_i,
  input pc_t upd_addr1_i,
  input logic upd_branch1_i,
  input logic upd_jal1_i,
  input logic upd_jump1_i,
  input logic upd_taken1_i,
  input pc_t upd_taddr1_i,
  input sat_t upd_tsat1_i,
  btb_if.write btb,
  output logic pred_hazard0_o,
  output logic pred_hazard1_o,
  output logic pred_miss_o,
  output pc_t pred_maddr_o
);

  // Only taken outcomes train, so the counter only moves up.
  function automatic sat_t sat_inc(input sat_t sat);
    return (sat == '1) ? sat : sat_t'(sat + 1'b1);
  endfunction

  function automatic void slot_miss(
    input logic clear,
    input logic taken,
    input logic jump,
    input logic branch,
    input pc_t taddr,
    input pc_t addr,
    input pc_t npc,
    output logic hazard,
    output pc_t redirect
  );
    hazard = 1'b0;
    redirect = '0;
    if (!clear) begin
      if (taken && jump) begin
        hazard = (addr != taddr); // Wrong target.
        redirect = addr;
      end else if (taken && branch) begin
        hazard = 1'b1; // Predicted taken, fell through.
        redirect = npc;
      end else if (!taken && jump) begin
        hazard = 1'b1;
        redirect = addr;
      end
    end
  endfunction

  logic train0;
  logic train1;
  pc_t sel_pc;
  pc_t sel_addr;
  sat_t sel_tsat;

  logic hazard0;
  logic hazard1;
  pc_t redirect0;
  pc_t redirect1;

  logic miss0_q;
  logic miss1_q;
  pc_t maddr0_q;
  pc_t maddr1_q;

  assign train0 = (upd_jal0_i | upd_branch0_i) & upd_jump0_i;
  assign train1 = (upd_jal1_i | upd_branch1_i) & upd_jump1_i;

  // Slot 0 owns the single write port when it jumped.
  assign sel_pc = upd_jump0_i ? upd_pc0_i : upd_pc1_i;
  assign sel_addr = upd_jump0_i ? upd_addr0_i : upd_addr1_i;
  assign sel_tsat = upd_jump0_i ? upd_tsat0_i : upd_tsat1_i;

  assign btb.wen = ~clear_i & (train0 | train1);
  assign btb.waddr = pc_index(sel_pc);
  assign btb.wdata = make_entry(pc_tag(sel_pc), sel_addr, sat_inc(sel_tsat));

  always_comb begin
    slot_miss(clear_i, upd_taken0_i, upd_jump0_i, upd_branch0_i,
              upd_taddr0_i, upd_addr0_i, upd_npc0_i, hazard0, redirect0);
    slot_miss(clear_i, upd_taken1_i, upd_jump1_i, upd_branch1_i,
              upd_taddr1_i, upd_addr1_i, upd_npc1_i, hazard1, redirect1);
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      miss0_q <= 1'b0;
      miss1_q <= 1'b0;
      maddr0_q <= '0;
      maddr1_q <= '0;
    end else begin
      miss0_q <= hazard0;
      miss1_q <= hazard1;
      maddr0_q <= redirect0;
      maddr1_q <= redirect1;
    end
  end

  assign pred_hazard0_o = hazard0;
  assign pred_hazard1_o = hazard1;
  assign pred_miss_o = miss0_q | miss1_q;
  assign pred_maddr_o = miss0_q ? maddr0_q : maddr1_q; // Older slot first.

endmodule

/* verilog/btac.sv */
`timescale 1ns/1ps

module btac import btac_pkg::*; (
  input logic clock,
  input logic reset,
  input pc_t get_pc0_i,
  input pc_t get_pc1_i,
  input logic stall_i,
  input logic clear_i,
  input pc_t upd_pc0_i,
  input pc_t upd_npc0_i,
  input pc_t upd_addr0_i,
  input logic upd_branch0_i,
  input logic upd_jal0_i,
  input logic upd_jump0_i,
  input logic upd_taken0_i,
  input pc_t upd_taddr0_i,
  input sat_t upd_tsat0_i,
  input pc_t upd_pc1_i,
  input pc_t upd_npc1_i,
  input pc_t upd_addr1_i,
  input logic upd_branch1_i,
  input logic upd_jal1_i,
  input logic upd_jump1_i,
  input logic upd_taken1_i,
  input pc_t upd_taddr1_i,
  input sat_t upd_tsat1_i,
  output logic pred_taken0_o,
  output logic pred_taken1_o,
  output pc_t pred_taddr0_o,
  output pc_t pred_taddr1_o,
  output sat_t pred_tsat0_o,
  output sat_t pred_tsat1_o,
  output logic pred_hazard0_o,
  output logic pred_hazard1_o,
  output logic pred_miss_o,
  output pc_t pred_maddr_o
);

  btb_if btb ();

  btb_mem u_mem (
    .clock (clock),
    .btb (btb.mem)
  );

  // Fetch side.
  btac_lookup u_lookup (
    .clock (clock),
    .reset (reset),
    .get_pc0_i (get_pc0_i),
    .get_pc1_i (get_pc1_i),
    .stall_i (stall_i),
    .clear_i (clear_i),
    .btb (btb.read),
    .pred_taken0_o (pred_taken0_o),
    .pred_taken1_o (pred_taken1_o),
    .pred_taddr0_o (pred_taddr0_o),
    .pred_taddr1_o (pred_taddr1_o),
    .pred_tsat0_o (pred_tsat0_o),
    .pred_tsat1_o (pred_tsat1_o)
  );

  // Execute side.
  btac_update u_update (
    .clock (clock),
    .reset (reset),
    .clear_i (clear_i),
    .upd_pc0_i (upd_pc0_i),
    .upd_npc0_i (upd_npc0_i),
    .upd_addr0_i (upd_addr0_i),
    .upd_branch0_i (upd_branch0_i),
    .upd_jal0_i (upd_jal0_i),
    .upd_jump0_i (upd_jump0_i),
    .upd_taken0_i (upd_taken0_i),
    .upd_taddr0_i (upd_taddr0_i),
    .upd_tsat0_i (upd_tsat0_i),
    .upd_pc1_i (upd_pc1_i),
    .upd_npc1_i (upd_npc1_i),
    .upd_addr1_i (upd_addr1_i),
    .upd_branch1_i (upd_branch1_i),
    .upd_jal1_i (upd_jal1_i),
    .upd_jump1_i (upd_jump1_i),
    .upd_taken1_i (upd_taken1_i),
    .upd_taddr1_i (upd_taddr1_i),
    .upd_tsat1_i (upd_tsat1_i),
    .btb (btb.write),
    .pred_hazard0_o (pred_hazard0_o),
    .pred_hazard1_o (pred_hazard1_o),
    .pred_miss_o (pred_miss_o),
    .pred_maddr_o (pred_maddr_o)
  );

endmodule

/* verif/btac_assertions.sv */
`timescale 1ns/1ps

module btac_assertions (
  input logic clock,
  input logic reset,
  input logic clear_i,
  input logic wen_i,
  input logic hazard0_i,
  input logic hazard1_i,
  input logic miss_i
);

  property no_write_on_clear;
    @(posedge clock) clear_i |-> !wen_i;
  endproperty

  // Registered miss trails the hazards by one cycle.
  property miss_follows_hazard;
    @(posedge clock) $past(reset) |-> (miss_i == $past(hazard0_i | hazard1_i));
  endproperty

  property idle_after_reset;
    @(posedge clock) $rose(reset) |-> !wen_i;
  endproperty

  assert property (no_write_on_clear) else $error("wen high while clear_i is high");
  assert property (miss_follows_hazard) else $error("pred_miss_o does not follow hazards");
  assert property (idle_after_reset) else $error("write in the first cycle after reset");

endmodule

bind btac_update btac_assertions u_assertions (
  .clock (clock),
  .reset (reset),
  .clear_i (clear_i),
  .wen_i (btb.wen),
  .hazard0_i (pred_hazard0_o),
  .hazard1_i (pred_hazard1_o),
  .miss_i (pred_miss_o)
);

/* verif/tb_btac.sv */
`timescale 1ns/1ps

module tb_btac;

  localparam int directed_cycles = 40;
  localparam int random_cycles = 300;
  localparam int cycle_limit = 3 + directed_cycles + random_cycles + 20; // Reset plus margin.

  logic clock;
  logic reset;
  logic stall;
  logic clear;
  logic [31:0] get_pc [2];
  logic [31:0] upd_pc [2], upd_npc [2], upd_addr [2], upd_taddr [2];
  logic upd_branch [2], upd_jal [2], upd_jump [2], upd_taken [2];
  logic [1:0] upd_tsat [2];
  logic pred_taken [2], pred_hazard [2];
  logic [31:0] pred_taddr [2];
  logic [1:0] pred_tsat [2];
  logic pred_miss;
  logic [31:0] pred_maddr;

  // Reference copy of the buffer and of the registered state.
  logic [24:0] ref_tag [64] = '{default: '0};
  logic [31:0] ref_target [64] = '{default: '0};
  logic [1:0] ref_sat [64] = '{default: '0};
  logic [31:0] ref_pc [2], ref_maddr [2];
  logic ref_miss [2];

  logic [31:0] lcg_state = 32'hf049;
  int cycles = 0;
  int errors = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  btac UUT (
    .clock (clock),
    .reset (reset),
    .get_pc0_i (get_pc[0]),
    .get_pc1_i (get_pc[1]),
    .stall_i (stall),
    .clear_i (clear),
    .upd_pc0_i (upd_pc[0]),
    .upd_npc0_i (upd_npc[0]),
    .upd_addr0_i (upd_addr[0]),
    .upd_branch0_i (upd_branch[0]),
    .upd_jal0_i (upd_jal[0]),
    .upd_jump0_i (upd_jump[0]),
    .upd_taken0_i (upd_taken[0]),
    .upd_taddr0_i (upd_taddr[0]),
    .upd_tsat0_i (upd_tsat[0]),
    .upd_pc1_i (upd_pc[1]),
    .upd_npc1_i (upd_npc[1]),
    .upd_addr1_i (upd_addr[1]),
    .upd_branch1_i (upd_branch[1]),
    .upd_jal1_i (upd_jal[1]),
    .upd_jump1_i (upd_jump[1]),
    .upd_taken1_i (upd_taken[1]),
    .upd_taddr1_i (upd_taddr[1]),
    .upd_tsat1_i (upd_tsat[1]),
    .pred_taken0_o (pred_taken[0]),
    .pred_taken1_o (pred_taken[1]),
    .pred_taddr0_o (pred_taddr[0]),
    .pred_taddr1_o (pred_taddr[1]),
    .pred_tsat0_o (pred_tsat[0]),
    .pred_tsat1_o (pred_tsat[1]),
    .pred_hazard0_o (pred_hazard[0]),
    .pred_hazard1_o (pred_hazard[1]),
    .pred_miss_o (pred_miss),
    .pred_maddr_o (pred_maddr)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Two tags over all indices, so hits and aliases both occur.
  function automatic logic [31:0] random_pc();
    logic [31:0] r;
    r = next_random();
    return {24'h0, r[23:17], 1'b0};
  endfunction

  function automatic logic [1:0] sat_up(input logic [1:0] sat);
    return (sat == 2'd3) ? sat : sat + 2'd1;
  endfunction

  // Expected {hazard, redirect} of slot n.
  function automatic logic [32:0] expected_miss(input int n);
    if (clear) return '0;
    if (upd_taken[n] && upd_jump[n]) return {upd_addr[n] != upd_taddr[n], upd_addr[n]};
    if (upd_taken[n] && upd_branch[n]) return {1'b1, upd_npc[n]};
    if (!upd_taken[n] && upd_jump[n]) return {1'b1, upd_addr[n]};
    return '0;
  endfunction

  // Expected {taken, target, counter} for the PC registered in slot n.
  function automatic logic [34:0] expected_pred(input int n);
    logic [5:0] idx;
    idx = ref_pc[n][6:1];
    if (stall || clear) return '0;
    return {ref_tag[idx] == ref_pc[n][31:7] && ref_sat[idx][1], ref_target[idx], ref_sat[idx]};
  endfunction

  task automatic model_edge();
    logic [32:0] miss;
    int s;
    s = upd_jump[0] ? 0 : 1; // Slot 0 wins the write.
    if (!clear && ((upd_jump[0] && (upd_jal[0] || upd_branch[0])) ||
                   (upd_jump[1] && (upd_jal[1] || upd_branch[1])))) begin
      ref_tag[upd_pc[s][6:1]] = upd_pc[s][31:7];
      ref_target[upd_pc[s][6:1]] = upd_addr[s];
      ref_sat[upd_pc[s][6:1]] = sat_up(upd_tsat[s]);
    end
    for (int n = 0; n < 2; n++) begin
      miss = expected_miss(n);
      ref_miss[n] = reset && miss[32];
      ref_maddr[n] = reset ? miss[31:0] : '0;
      if (!reset) begin
        ref_pc[n] = '0;
      end else if (!clear) begin
        ref_pc[n] = get_pc[n];
      end
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    errors++;
    test_errors++;
  endtask

  task automatic compare_outputs();
    logic [34:0] pred;
    logic [32:0] miss;
    for (int n = 0; n < 2; n++) begin
      pred = expected_pred(n);
      miss = expected_miss(n);
      if (pred_taken[n] !== pred[34])
        report_mismatch($sformatf("pred_taken%0d_o", n), 32'(pred_taken[n]), 32'(pred[34]));
      if (pred_taddr[n] !== pred[33:2])
        report_mismatch($sformatf("pred_taddr%0d_o", n), pred_taddr[n], pred[33:2]);
      if (pred_tsat[n] !== pred[1:0])
        report_mismatch($sformatf("pred_tsat%0d_o", n), 32'(pred_tsat[n]), 32'(pred[1:0]));
      if (pred_hazard[n] !== miss[32])
        report_mismatch($sformatf("pred_hazard%0d_o", n), 32'(pred_hazard[n]), 32'(miss[32]));
    end
    if (pred_miss !== (ref_miss[0] || ref_miss[1]))
      report_mismatch("pred_miss_o", 32'(pred_miss), 32'(ref_miss[0] || ref_miss[1]));
    if (pred_maddr !== (ref_miss[0] ? ref_maddr[0] : ref_maddr[1]))
      report_mismatch("pred_maddr_o", pred_maddr, ref_miss[0] ? ref_maddr[0] : ref_maddr[1]);
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic idle();
    stall = 1'b0;
    clear = 1'b0;
    for (int n = 0; n < 2; n++) begin
      get_pc[n] = '0;
      upd_pc[n] = '0;
      upd_npc[n] = '0;
      upd_addr[n] = '0;
      upd_taddr[n] = '0;
      upd_branch[n] = 1'b0;
      upd_jal[n] = 1'b0;
      upd_jump[n] = 1'b0;
      upd_taken[n] = 1'b0;
      upd_tsat[n] = '0;
    end
  endtask

  // Kind is {jal, branch, jump}.
  task automatic resolve(input int n, input logic [31:0] pc, input logic [31:0] addr,
                         input logic [2:0] kind, input logic taken,
                         input logic [31:0] taddr, input logic [1:0] tsat);
    upd_pc[n] = pc;
    upd_npc[n] = pc + 32'd4;
    upd_addr[n] = addr;
    {upd_jal[n], upd_branch[n], upd_jump[n]} = kind;
    upd_taken[n] = taken;
    upd_taddr[n] = taddr;
    upd_tsat[n] = tsat;
  endtask

  task automatic random_cycle();
    logic [31:0] r;
    for (int n = 0; n < 2; n++) begin
      r = next_random();
      get_pc[n] = random_pc();
      resolve(n, random_pc(), next_random(), r[26:24], r[27], next_random(), r[30:29]);
      if (r[28]) upd_taddr[n] = upd_addr[n]; // Correct target now and then.
    end
    r = next_random();
    stall = (r[31:29] == 3'd0);
    clear = (r[28:26] == 3'd0);
  endtask

  // Two idle cycles flush the last lookup into this test's count.
  task automatic end_test(input string name);
    idle();
    next_cycle();
    next_cycle();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run exceeded %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  // Model steps on the edge; outputs are compared late in the cycle.
  always @(posedge clock) begin
    model_edge();
    #3;
    if (reset) compare_outputs();
  end

  initial begin
    idle();
    reset = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b1;

    for (int i = 0; i < 4; i++) begin
      get_pc[0] = next_random();
      get_pc[1] = next_random();
      next_cycle();
    end
    end_test("reset");

    // Lookup in the same cycle as the write.
    get_pc[0] = 32'h0000_1234;
    resolve(0, 32'h0000_1234, 32'h0000_8000, 3'b101, 1'b0, '0, 2'd1);
    next_cycle();
    idle();
    get_pc[1] = 32'h0000_2468;
    resolve(1, 32'h0000_2468, 32'h0000_9000, 3'b101, 1'b0, '0, 2'd0);
    next_cycle();
    idle();
    get_pc[1] = 32'h0000_3456;
    resolve(1, 32'h0000_3456, 32'h0000_a000, 3'b011, 1'b1, 32'h0000_a000, 2'd3);
    next_cycle();
    end_test("train");

    get_pc[0] = 32'h0000_1334; // Index of 0x1234, other tag.
    next_cycle();
    end_test("alias");

    get_pc[0] = 32'h0000_1234;
    get_pc[1] = 32'h0000_3456;
    stall = 1'b1;
    next_cycle();
    next_cycle(); // Trained PCs registered, outputs still gated.
    stall = 1'b0;
    next_cycle();
    clear = 1'b1;
    get_pc[0] = 32'h0000_0050;
    resolve(0, 32'h0000_0050, 32'h0000_b000, 3'b101, 1'b0, '0, 2'd2);
    next_cycle();
    idle();
    get_pc[0] = 32'h0000_0050;
    next_cycle();
    end_test("stall_clear");

    resolve(0, 32'h0000_0100, 32'h0000_c000, 3'b101, 1'b1, 32'h0000_c004, 2'd2);
    next_cycle();
    idle();
    resolve(1, 32'h0000_0200, 32'h0000_d000, 3'b010, 1'b1, 32'h0000_d000, 2'd2);
    next_cycle();
    idle();
    resolve(0, 32'h0000_0300, 32'h0000_e000, 3'b011, 1'b0, '0, 2'd0);
    resolve(1, 32'h0000_0400, 32'h0000_f000, 3'b010, 1'b1, 32'h0000_f000, 2'd1);
    next_cycle();
    end_test("miss");

    get_pc[0] = 32'h0000_0500;
    get_pc[1] = 32'h0000_0600;
    resolve(0, 32'h0000_0500, 32'h0001_0000, 3'b101, 1'b1, 32'h0001_0000, 2'd1);
    resolve(1, 32'h0000_0600, 32'h0002_0000, 3'b101, 1'b1, 32'h0002_0000, 2'd1);
    next_cycle();
    end_test("dual_write");

    for (int i = 0; i < random_cycles; i++) begin
      random_cycle();
      next_cycle();
    end
    end_test("random");

    $display("Summary: %0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* compile.f */
verilog/btac_pkg.sv
verilog/btb_if.sv
verilog/btb_mem.sv
verilog/btac_lookup.sv
verilog/btac_update.sv
verilog/btac.sv
verif/btac_assertions.sv
verif/tb_btac.sv

/* run.sh */
#!/bin/sh
# Build the BTAC testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_btac -f compile.f -Mdir obj_dir -o tb_btac
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_btac > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$log"; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation passed"
exit 0
